/* flist.f */
+incdir+src
src/eth_rx_pkg.sv
src/eth_crc32.sv
src/eth_rx_port.sv
src/eth_rx_drain.sv
src/eth_rx_top.sv
test/eth_rx_sva.sv
test/eth_rx_tb.sv

/* src/eth_crc32.sv */
`timescale 1ns/1ps
`default_nettype none

module eth_crc32 (
   input  wire               RX_CLK,
   input  wire               rx_rst,
   input  wire               start,
   input  wire               data_en,
   input  wire eth_rx_pkg::byte_t data_in,
   output logic [31:0]       crc
);

   localparam logic [31:0] POLY = 32'h04c11db7;

   logic [31:0] crc_next;

   // lsb of each byte goes in first
   // register held msb-first, so the good-frame residue reads c704dd7b
   always_comb begin
      crc_next = crc;
      for (int i = 0; i < 8; i++) begin
         if (crc_next[31] ^ data_in[i]) begin
            crc_next = {crc_next[30:0], 1'b0} ^ POLY;
         end else begin
            crc_next = {crc_next[30:0], 1'b0};
         end
      end
   end

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         crc <= '1;
      end else if (start) begin
         crc <= '1;
      end else if (data_en) begin
         crc <= crc_next;
      end
   end

endmodule

`default_nettype wire

/* src/eth_rx_drain.sv */
`timescale 1ns/1ps
`include "eth_rx_settings.svh"
`default_nettype none

module eth_rx_drain (
   input  wire                                   RX_CLK,
   input  wire                                   rx_rst,
   input  wire [`ETH_NPORTS-1:0]                 frame_ready,
   input  wire [`ETH_NPORTS*(`ETH_BUF_AW+1)-1:0] frame_len,
   input  wire [`ETH_NPORTS-1:0]                 crc_ok,
   input  wire [`ETH_NPORTS*8-1:0]               rd_data,
   output eth_rx_pkg::buf_addr_t                 rd_addr,
   output logic [`ETH_NPORTS-1:0]                frame_release,
   output logic                                  out_valid,
   output logic                                  out_first,
   output logic                                  out_last,
   output eth_rx_pkg::byte_t                     out_data,
   output eth_rx_pkg::port_idx_t                 out_port,
   output logic                                  out_crc_ok
);

   import eth_rx_pkg::*;

   localparam int NP = `ETH_NPORTS;
   localparam int LW = $bits(buf_addr_t);

   port_idx_t cur_port;
   port_idx_t grant_port;
   logic      grant_any;
   logic      grant;
   logic      active;
   logic      busy;
   buf_addr_t len_q;
   logic      crc_q;
   buf_addr_t issue_len;
   logic      issue;
   logic      issue_last;
   logic      s1_v;
   logic      s1_first;
   logic      s1_last;
   byte_t     sel_data;

   // first ready port after the one served last
   always_comb begin
      int idx;
      grant_any  = 1'b0;
      grant_port = '0;
      for (int i = 1; i <= NP; i++) begin
         idx = (int'(cur_port) + i) % NP;
         if (!grant_any && frame_ready[idx]) begin
            grant_any  = 1'b1;
            grant_port = port_idx_t'(idx);
         end
      end
   end

   assign grant = grant_any && !active;

   // address 0 is already on rd_addr when the grant is taken
   assign issue_len  = grant ? frame_len[grant_port*LW +: LW] : len_q;
   assign issue      = grant || busy;
   assign issue_last = issue && (rd_addr == issue_len - 1'b1);

   assign sel_data = rd_data[cur_port*8 +: 8];

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         cur_port      <= port_idx_t'(NP - 1);
         active        <= 1'b0;
         busy          <= 1'b0;
         rd_addr       <= '0;
         s1_v          <= 1'b0;
         s1_first      <= 1'b0;
         s1_last       <= 1'b0;
         out_valid     <= 1'b0;
         out_first     <= 1'b0;
         out_last      <= 1'b0;
         frame_release <= '0;
      end else begin
         frame_release <= '0;
         if (grant) begin
            cur_port <= grant_port;
            active   <= 1'b1;
            busy     <= 1'b1;
         end
         if (issue) begin
            rd_addr <= issue_last ? '0 : rd_addr + 1'b1;
         end
         if (issue_last) begin
            busy <= 1'b0;
         end
         // read data stage, then output stage
         s1_v      <= issue;
         s1_first  <= grant;
         s1_last   <= issue_last;
         out_valid <= s1_v;
         out_first <= s1_first;
         out_last  <= s1_last;
         if (s1_last) begin
            frame_release[cur_port] <= 1'b1;
         end
         // free for a new grant the cycle after release
         if (out_last) begin
            active <= 1'b0;
         end
      end
   end

   always_ff @(posedge RX_CLK) begin
      if (grant) begin
         len_q <= issue_len;
         crc_q <= crc_ok[grant_port];
      end
      out_data   <= sel_data;
      out_port   <= cur_port;
      out_crc_ok <= crc_q;
   end

endmodule

`default_nettype wire

/* src/eth_rx_pkg.sv */
`include "eth_rx_settings.svh"
`default_nettype none

package eth_rx_pkg;

   typedef logic [7:0] byte_t;

   // same 48 bits, seen whole or as six octets
   typedef union packed {
      logic [47:0]     raw;
      logic [5:0][7:0] octets;
   } mac_addr_u;

   // one extra bit so a completely full buffer length still fits
   typedef logic [`ETH_BUF_AW:0] buf_addr_t;

   localparam int PORT_IDX_W = (`ETH_NPORTS > 1) ? $clog2(`ETH_NPORTS) : 1;

   typedef logic [PORT_IDX_W-1:0] port_idx_t;

endpackage

`default_nettype wire

/* src/eth_rx_port.sv */
`timescale 1ns/1ps
`include "eth_rx_settings.svh"
`default_nettype none

module eth_rx_port #(
   parameter int PORT_ID = 0
) (
   input  wire                        RX_CLK,
   input  wire                        rx_rst,
   input  wire                        rx_dv,
   input  wire [3:0]                  rx_data,
   input  wire eth_rx_pkg::buf_addr_t rd_addr,
   input  wire                        frame_release,
   output logic                       frame_ready,
   output eth_rx_pkg::buf_addr_t      frame_len,
   output logic                       crc_ok,
   output eth_rx_pkg::byte_t          rd_data
);

   import eth_rx_pkg::*;

   localparam int DEPTH = 2 ** `ETH_BUF_AW;

   localparam logic [47:0] MAC_BASE   = `ETH_MAC_BASE;
   localparam logic [47:0] OWN_ADDR   = {MAC_BASE[47:8], MAC_BASE[7:0] + 8'(PORT_ID)};
   localparam logic [47:0] BCAST_ADDR = '1;

   localparam logic [2:0] S_IDLE    = 3'd0;
   localparam logic [2:0] S_DEST    = 3'd1;
   localparam logic [2:0] S_PAYLOAD = 3'd2;
   localparam logic [2:0] S_HOLD    = 3'd3;
   localparam logic [2:0] S_DISCARD = 3'd4;

   logic [2:0]  state;
   logic [3:0]  lo_nib;
   logic        phase;
   byte_t       byte_q;
   logic        wr_q;
   buf_addr_t   wr_addr;
   mac_addr_u   dest_q;
   mac_addr_u   dest_next;
   logic        in_frame;
   logic        sfd_hit;
   logic        buf_full;
   logic        wr_en;
   logic        dest_done;
   logic        dest_match;
   logic [31:0] crc;
   byte_t       mem [DEPTH];

   assign in_frame = (state == S_DEST) || (state == S_PAYLOAD);

   // previous nibble is the low half, current one the high half
   assign sfd_hit  = rx_dv && ({rx_data, lo_nib} == `ETH_SFD);

   assign buf_full = wr_addr[`ETH_BUF_AW];
   assign wr_en    = in_frame && wr_q && !buf_full;

   // sixth destination byte is being written this cycle
   assign dest_done = (state == S_DEST) && wr_q && (wr_addr == buf_addr_t'(5));

   always_comb dest_next.octets = {dest_q.octets[4:0], byte_q};

   assign dest_match = (dest_next.raw == OWN_ADDR) || (dest_next.raw == BCAST_ADDR);

   assign frame_ready = (state == S_HOLD);
   assign frame_len   = wr_addr;
   assign crc_ok      = (crc == `ETH_CRC_RESIDUE);

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         state   <= S_IDLE;
         phase   <= 1'b0;
         wr_q    <= 1'b0;
         wr_addr <= '0;
      end else begin
         wr_q <= 1'b0;
         if (wr_en) begin
            wr_addr <= wr_addr + 1'b1;
         end
         // nibble pairing only inside a frame
         if (in_frame && rx_dv) begin
            phase <= ~phase;
            wr_q  <= phase;
         end
         case (state)
            S_IDLE: begin
               if (sfd_hit) begin
                  state   <= S_DEST;
                  phase   <= 1'b0;
                  wr_addr <= '0;
               end
            end
            S_DEST, S_PAYLOAD: begin
               if (wr_q && buf_full) begin
                  state <= S_DISCARD;
               end else if (dest_done && !dest_match) begin
                  state <= S_DISCARD;
               end else if (!rx_dv) begin
                  // too short to carry a destination means nothing to hold
                  state <= (state == S_PAYLOAD || dest_done) ? S_HOLD : S_IDLE;
               end else if (dest_done) begin
                  state <= S_PAYLOAD;
               end
            end
            S_HOLD: begin
               if (frame_release) begin
                  state <= rx_dv ? S_DISCARD : S_IDLE;
               end
            end
            S_DISCARD: begin
               if (!rx_dv) begin
                  state <= S_IDLE;
               end
            end
            default: begin
               state <= S_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge RX_CLK) begin
      if (rx_dv) begin
         lo_nib <= rx_data;
      end
      if (in_frame && rx_dv && phase) begin
         byte_q <= {rx_data, lo_nib};
      end
      if (wr_en && state == S_DEST) begin
         dest_q <= dest_next;
      end
   end

   // frame buffer, one cycle read latency
   always_ff @(posedge RX_CLK) begin
      if (wr_en) begin
         mem[wr_addr[`ETH_BUF_AW-1:0]] <= byte_q;
      end
      rd_data <= mem[rd_addr[`ETH_BUF_AW-1:0]];
   end

   eth_crc32 crc_inst (
      .RX_CLK  (RX_CLK),
      .rx_rst  (rx_rst),
      .start   (state == S_IDLE),
      .data_en (wr_en),
      .data_in (byte_q),
      .crc     (crc)
   );

endmodule

`default_nettype wire

/* src/eth_rx_settings.svh */
`ifndef ETH_RX_SETTINGS_SVH
`define ETH_RX_SETTINGS_SVH

// number of MII receive ports
`define ETH_NPORTS 4

// frame buffer address width per port, 2**9 = 512 bytes
`define ETH_BUF_AW 9

// start-of-frame delimiter as assembled, low nibble first
`define ETH_SFD 8'hd5

// port p answers to this address with p added to the last octet
`define ETH_MAC_BASE 48'h02_00_5e_10_00_00

// crc register after a good frame plus its fcs, not inverted
`define ETH_CRC_RESIDUE 32'hc704dd7b

`endif

/* src/eth_rx_top.sv */
`timescale 1ns/1ps
`include "eth_rx_settings.svh"
`default_nettype none

module eth_rx_top (
   input  wire                     RX_CLK,
   input  wire                     rx_rst,
   input  wire [`ETH_NPORTS-1:0]   rx_dv,
   input  wire [4*`ETH_NPORTS-1:0] rx_data,
   output logic                    out_valid,
   output logic                    out_first,
   output logic                    out_last,
   output eth_rx_pkg::byte_t       out_data,
   output eth_rx_pkg::port_idx_t   out_port,
   output logic                    out_crc_ok
);

   import eth_rx_pkg::*;

   localparam int LW = $bits(buf_addr_t);

   wire [`ETH_NPORTS-1:0]    frame_ready;
   wire [`ETH_NPORTS*LW-1:0] frame_len;
   wire [`ETH_NPORTS-1:0]    crc_ok;
   wire [`ETH_NPORTS*8-1:0]  rd_data;
   wire [`ETH_NPORTS-1:0]    frame_release;
   wire buf_addr_t           rd_addr;

   // one receive port per mii pin set, shared read address
   generate
      for (genvar p = 0; p < `ETH_NPORTS; p++) begin : g_port
         eth_rx_port #(
            .PORT_ID (p)
         ) port_inst (
            .RX_CLK        (RX_CLK),
            .rx_rst        (rx_rst),
            .rx_dv         (rx_dv[p]),
            .rx_data       (rx_data[4*p +: 4]),
            .rd_addr       (rd_addr),
            .frame_release (frame_release[p]),
            .frame_ready   (frame_ready[p]),
            .frame_len     (frame_len[LW*p +: LW]),
            .crc_ok        (crc_ok[p]),
            .rd_data       (rd_data[8*p +: 8])
         );
      end
   endgenerate

   eth_rx_drain drain_inst (
      .RX_CLK        (RX_CLK),
      .rx_rst        (rx_rst),
      .frame_ready   (frame_ready),
      .frame_len     (frame_len),
      .crc_ok        (crc_ok),
      .rd_data       (rd_data),
      .rd_addr       (rd_addr),
      .frame_release (frame_release),
      .out_valid     (out_valid),
      .out_first     (out_first),
      .out_last      (out_last),
      .out_data      (out_data),
      .out_port      (out_port),
      .out_crc_ok    (out_crc_ok)
   );

endmodule

`default_nettype wire

/* test/eth_rx_sva.sv */
`timescale 1ns/1ps
`include "eth_rx_settings.svh"
`default_nettype none

module eth_rx_sva (
   input wire                   RX_CLK,
   input wire                   rx_rst,
   input wire [`ETH_NPORTS-1:0] frame_release,
   input wire                   out_valid,
   input wire                   out_first,
   input wire                   out_last
);

   int unsigned fail_count = 0;

   // release goes out together with the last byte of the frame
   release_with_last: assert property (@(posedge RX_CLK) disable iff (rx_rst)
      (|frame_release) == out_last)
      else begin
         fail_count++;
         $error("release and out_last are not aligned");
      end

   // a single port, for a single cycle
   release_one_cycle: assert property (@(posedge RX_CLK) disable iff (rx_rst)
      (|frame_release) |-> $onehot(frame_release) ##1 !(|frame_release))
      else begin
         fail_count++;
         $error("release is not a one-cycle pulse on one port");
      end

   marks_need_valid: assert property (@(posedge RX_CLK) disable iff (rx_rst)
      (out_first || out_last) |-> out_valid)
      else begin
         fail_count++;
         $error("out_first or out_last without out_valid");
      end

   quiet_after_reset: assert property (@(posedge RX_CLK)
      $fell(rx_rst) |-> !out_valid [*3])
      else begin
         fail_count++;
         $error("out_valid too soon after reset");
      end

endmodule

`default_nettype wire

/* test/eth_rx_tb.sv */
`timescale 1ns/1ps
`include "eth_rx_settings.svh"
`default_nettype none

module eth_rx_tb;

   import eth_rx_pkg::*;

   localparam int NP       = `ETH_NPORTS;
   localparam int NROWS    = 16;
   localparam int MAX_NIB  = 2048;
   localparam int MAX_BYTE = 1024;
   localparam int TIMEOUT  = 8000;
   localparam logic [47:0] FOREIGN = 48'h00_1b_21_3c_4d_5e;

   // destination kinds
   localparam int D_OWN   = 0;
   localparam int D_BCAST = 1;
   localparam int D_OTHER = 2;
   localparam int D_FRGN  = 3;

   logic            RX_CLK;
   logic            rx_rst;
   logic [NP-1:0]   rx_dv;
   logic [4*NP-1:0] rx_data;
   logic            out_valid;
   logic            out_first;
   logic            out_last;
   byte_t           out_data;
   port_idx_t       out_port;
   logic            out_crc_ok;

   // one row per frame
   int   t_port [NROWS];
   int   t_kind [NROWS];
   int   t_len  [NROWS];
   logic t_bad  [NROWS];
   logic t_ovl  [NROWS];

   logic [31:0] lfsr;
   byte_t       frm [MAX_BYTE];
   logic [3:0]  nib [NP][MAX_NIB];
   int          nib_cnt [NP];
   int          nib_start [NP];

   // a port holds one frame, so one outstanding frame per port
   logic  exp_pend [NP];
   int    exp_len  [NP];
   logic  exp_crc  [NP];
   byte_t exp_data [NP][MAX_BYTE];

   int   error_count;
   int   frames_expected;
   int   frames_seen;
   logic in_pkt;
   logic pkt_skip;
   int   pkt_port;
   int   pkt_idx;

   eth_rx_top eth_rx_top_inst (
      .RX_CLK     (RX_CLK),
      .rx_rst     (rx_rst),
      .rx_dv      (rx_dv),
      .rx_data    (rx_data),
      .out_valid  (out_valid),
      .out_first  (out_first),
      .out_last   (out_last),
      .out_data   (out_data),
      .out_port   (out_port),
      .out_crc_ok (out_crc_ok)
   );

   bind eth_rx_drain eth_rx_sva drain_sva_inst (
      .RX_CLK        (RX_CLK),
      .rx_rst        (rx_rst),
      .frame_release (frame_release),
      .out_valid     (out_valid),
      .out_first     (out_first),
      .out_last      (out_last)
   );

   initial begin
      RX_CLK = 1'b0;
      forever #4 RX_CLK = ~RX_CLK;
   end

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
         error_count++;
      end
   endtask

   // galois form, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h80200003;
      end
      return s >> 1;
   endfunction

   task automatic rand_byte(output byte_t b);
      for (int i = 0; i < 8; i++) begin
         lfsr = lfsr_next(lfsr);
         b[i] = lfsr[0];
      end
   endtask

   // standard ethernet fcs over frm[0..n-1]
   function automatic logic [31:0] fcs_of(input int n);
      logic [31:0] c;
      c = 32'hffffffff;
      for (int i = 0; i < n; i++) begin
         c = c ^ {24'h0, frm[i]};
         for (int k = 0; k < 8; k++) begin
            c = c[0] ? ((c >> 1) ^ 32'hedb88320) : (c >> 1);
         end
      end
      return ~c;
   endfunction

   function automatic logic [47:0] station_addr(input int p);
      logic [47:0] base;
      base = `ETH_MAC_BASE;
      return {base[47:8], base[7:0] + 8'(p)};
   endfunction

   task automatic set_row(input int r, input int port, input int kind, input int len,
                          input logic bad, input logic ovl);
      t_port[r] = port;
      t_kind[r] = kind;
      t_len[r]  = len;
      t_bad[r]  = bad;
      t_ovl[r]  = ovl;
   endtask

   task automatic load_table();
      set_row(0,  0, D_OWN,   46,  1'b0, 1'b0);
      set_row(1,  1, D_OWN,   60,  1'b0, 1'b0);
      set_row(2,  2, D_BCAST, 50,  1'b0, 1'b0);
      set_row(3,  3, D_OTHER, 40,  1'b0, 1'b0);
      set_row(4,  0, D_FRGN,  40,  1'b0, 1'b0);
      set_row(5,  1, D_OWN,   64,  1'b1, 1'b0);
      set_row(6,  0, D_OWN,   48,  1'b0, 1'b0);
      set_row(7,  1, D_BCAST, 52,  1'b0, 1'b1);
      set_row(8,  2, D_OWN,   70,  1'b1, 1'b1);
      set_row(9,  3, D_OWN,   46,  1'b0, 1'b1);
      // 536 bytes does not fit, the next one on port 2 must
      set_row(10, 2, D_OWN,   520, 1'b0, 1'b0);
      set_row(11, 2, D_OWN,   46,  1'b0, 1'b0);
      set_row(12, 3, D_BCAST, 100, 1'b0, 1'b0);
      set_row(13, 0, D_OTHER, 30,  1'b0, 1'b1);
      // exactly a full buffer
      set_row(14, 1, D_OWN,   496, 1'b0, 1'b1);
      set_row(15, 0, D_BCAST, 1,   1'b0, 1'b0);
   endtask

   // frame bytes into frm, then into the nibble stream of its port
   task automatic build_row(input int r);
      int          p;
      int          n;
      logic [47:0] dest;
      logic [47:0] src;
      logic [31:0] fcs;
      p = t_port[r];
      case (t_kind[r])
         D_OWN:   dest = station_addr(p);
         D_BCAST: dest = '1;
         D_OTHER: dest = station_addr((p + 1) % NP);
         default: dest = FOREIGN;
      endcase
      src = 48'h0a_00_00_00_00_00 | 48'(r);
      for (int i = 0; i < 6; i++) begin
         frm[i]     = dest[47-8*i -: 8];
         frm[6 + i] = src[47-8*i -: 8];
      end
      n = 12;
      for (int i = 0; i < t_len[r]; i++) begin
         rand_byte(frm[n]);
         n++;
      end
      fcs = fcs_of(n);
      if (t_bad[r]) begin
         fcs[r % 32] = ~fcs[r % 32];
      end
      for (int i = 0; i < 4; i++) begin
         frm[n] = fcs[8*i +: 8];
         n++;
      end
      // preamble then sfd, low nibble first
      for (int i = 0; i < 15; i++) begin
         nib[p][i] = 4'h5;
      end
      nib[p][15] = 4'hd;
      for (int i = 0; i < n; i++) begin
         nib[p][16 + 2*i] = frm[i][3:0];
         nib[p][17 + 2*i] = frm[i][7:4];
      end
      nib_cnt[p] = 16 + 2*n;
      if ((t_kind[r] == D_OWN || t_kind[r] == D_BCAST) && n <= 2 ** `ETH_BUF_AW) begin
         exp_pend[p] = 1'b1;
         exp_len[p]  = n;
         exp_crc[p]  = !t_bad[r];
         for (int i = 0; i < n; i++) begin
            exp_data[p][i] = frm[i];
         end
         frames_expected++;
      end
   endtask

   task automatic drive_ports();
      int              cyc;
      logic            busy;
      logic [NP-1:0]   dv_n;
      logic [4*NP-1:0] dat_n;
      cyc  = 0;
      busy = 1'b1;
      while (busy) begin
         @(posedge RX_CLK);
         busy  = 1'b0;
         dv_n  = '0;
         dat_n = '0;
         for (int p = 0; p < NP; p++) begin
            if (cyc < nib_start[p] + nib_cnt[p]) begin
               busy = 1'b1;
            end
            if (cyc >= nib_start[p] && cyc < nib_start[p] + nib_cnt[p]) begin
               dv_n[p]         = 1'b1;
               dat_n[4*p +: 4] = nib[p][cyc - nib_start[p]];
            end
         end
         rx_dv   <= dv_n;
         rx_data <= dat_n;
         cyc++;
      end
      repeat (12) @(posedge RX_CLK);
   endtask

   task automatic wait_drained();
      int   waited;
      logic pend;
      waited = 0;
      pend   = 1'b1;
      while (pend && waited < TIMEOUT) begin
         @(posedge RX_CLK);
         pend = 1'b0;
         for (int p = 0; p < NP; p++) begin
            pend = pend | exp_pend[p];
         end
         waited++;
      end
      if (pend) begin
         $display("timeout: expected frames not delivered within %0d cycles", TIMEOUT);
         error_count++;
         for (int p = 0; p < NP; p++) begin
            exp_pend[p] = 1'b0;
         end
      end
   endtask

   // output checker, sampled away from the active edge
   always @(negedge RX_CLK) begin
      if (out_valid) begin
         if (out_first) begin
            if (in_pkt) begin
               $display("a new frame started before the previous one ended");
               error_count++;
            end
            in_pkt   = 1'b1;
            pkt_port = int'(out_port);
            pkt_idx  = 0;
            pkt_skip = !exp_pend[pkt_port];
            if (pkt_skip) begin
               $display("frame from port %0d came out but none was expected", pkt_port);
               error_count++;
            end
         end
         if (!in_pkt) begin
            $display("byte came out while no frame was open");
            error_count++;
         end else if (!pkt_skip) begin
            check_value("out_port", out_port, pkt_port);
            if (pkt_idx < exp_len[pkt_port]) begin
               check_value("out_data", out_data, exp_data[pkt_port][pkt_idx]);
            end
            pkt_idx++;
            if (out_last) begin
               check_value("frame_len", pkt_idx, exp_len[pkt_port]);
               check_value("out_crc_ok", out_crc_ok, exp_crc[pkt_port]);
               exp_pend[pkt_port] = 1'b0;
               frames_seen++;
            end
         end
         if (out_last) begin
            in_pkt = 1'b0;
         end
      end else if (in_pkt) begin
         $display("frame from port %0d has a gap before its last byte", pkt_port);
         error_count++;
         in_pkt = 1'b0;
      end
   end

   initial begin
      int r;
      int q;
      int sva_fails;
      rx_rst          = 1'b1;
      rx_dv           = '0;
      rx_data         = '0;
      lfsr            = 32'd32477;
      error_count     = 0;
      frames_expected = 0;
      frames_seen     = 0;
      in_pkt          = 1'b0;
      pkt_skip        = 1'b0;
      for (int p = 0; p < NP; p++) begin
         exp_pend[p] = 1'b0;
      end
      load_table();
      repeat (5) @(posedge RX_CLK);
      rx_rst <= 1'b0;
      repeat (4) @(posedge RX_CLK);
      r = 0;
      while (r < NROWS) begin
         wait_drained();
         for (int p = 0; p < NP; p++) begin
            nib_cnt[p]   = 0;
            nib_start[p] = 0;
         end
         build_row(r);
         r++;
         q = 0;
         // overlapping rows start a little later on their own port
         while (r < NROWS && t_ovl[r]) begin
            q++;
            build_row(r);
            nib_start[t_port[r]] = 5*q + r % 3;
            r++;
         end
         drive_ports();
      end
      wait_drained();
      // room for any stray frame to show up
      repeat (200) @(posedge RX_CLK);
      sva_fails = int'(eth_rx_top_inst.drain_inst.drain_sva_inst.fail_count);
      $display("errors=%0d assertion_failures=%0d frames_expected=%0d frames_seen=%0d",
               error_count, sva_fails, frames_expected, frames_seen);
      if (error_count == 0 && sva_fails == 0 && frames_seen == frames_expected) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
